// File: compile.f
+incdir+common
common/pbuf_pkg.sv
common/page_wr_if.sv
hw/slice_counter.sv
hw/pkt_write_fsm.sv
free_list/free_page_queue.sv
page_store/page_ecc_encoder.sv
page_store/page_store.sv
hw/pbuf_bank_top.sv
verif/tb_clock_gen.sv
verif/pbuf_chk.sv
verif/pbuf_tb.sv

// File: run_sim.sh
#!/bin/sh
# build with Verilator, run, and look for the pass line in the output
verilator --binary --timing --assert -Wno-fatal -f compile.f --top-module pbuf_tb -o pbuf_sim \
    && ./obj_dir/pbuf_sim +verilator+error+limit+100 | tee /dev/stderr | grep -qx "STATUS: PASS" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

// File: verif/pbuf_tb.sv
`include "pbuf_defines.svh"

module pbuf_tb import pbuf_pkg::*; ();

    logic                     clk;
    logic                     rst_n;
    logic [`PBUF_BANK_AW-1:0] bank_idx;
    logic                     wr_data_vld;
    half_t                    wr_data;
    logic                     wr_end_of_packet;
    logic                     wr_join_request;
    port_t                    wr_dest_port;
    prio_t                    wr_prior;
    gaddr_t                   wr_head_addr;
    gaddr_t                   wr_tail_addr;
    logic                     concat_en;
    gaddr_t                   concat_head;
    gaddr_t                   concat_tail;
    logic                     rd_another_page;
    page_t                    rd_page;
    half_t                    rd_data;
    gaddr_t                   rd_next_page;
    ecc_t                     rd_ecc_code;
    logic                     init_done;
    logic [`PBUF_CNT_W-1:0]   free_count;

    int    seed;
    // next page the queue hands out, fill order
    page_t alloc_next;
    page_t first_a;
    page_t first_b;
    page_t first_c;
    page_t first_d;
    int    len_c;

    tb_clock_gen u_clk_gen (
        .clk   (clk),
        .rst_n (rst_n)
    );

    pbuf_bank_top UUT (.*);

    bind pbuf_bank_top pbuf_chk u_chk (.*);

    task automatic abort_run(input string why);
        $display("STATUS: FAIL");
        $fatal(1, "%s", why);
    endtask

    // fill of 64 entries, generous margin
    task automatic wait_for_init();
        int n;
        n = 0;
        while (init_done !== 1'b1 && n < 200) begin
            @(negedge clk);
            n++;
        end
        if (init_done !== 1'b1) begin
            abort_run("init_done did not rise within 200 cycles after reset");
        end
    endtask

    // header first, random payload, eop with the last halfword
    task automatic send_packet(input port_t port, input prio_t prio, input int nhalf,
                               output page_t first);
        half_t hdr;
        hdr        = half_t'($random(seed));
        hdr[3:0]   = port;
        hdr[6:4]   = prio;
        hdr[9:7]   = 3'((nhalf - 1) / 8);
        first      = alloc_next;
        alloc_next = alloc_next + page_t'((nhalf + 7) / 8);
        for (int i = 0; i < nhalf; i++) begin
            @(negedge clk);
            wr_data_vld      = 1'b1;
            wr_data          = (i == 0) ? hdr : half_t'($random(seed));
            wr_end_of_packet = (i == nhalf - 1);
        end
        @(negedge clk);
        wr_data_vld      = 1'b0;
        wr_end_of_packet = 1'b0;
        // idle gap before the next header
        repeat (3) @(negedge clk);
    endtask

    task automatic splice_packets(input gaddr_t head, input gaddr_t tail);
        @(negedge clk);
        concat_en   = 1'b1;
        concat_head = head;
        concat_tail = tail;
        @(negedge clk);
        concat_en   = 1'b0;
    endtask

    task automatic read_page(input page_t p);
        @(negedge clk);
        rd_another_page = 1'b1;
        rd_page         = p;
        @(negedge clk);
        rd_another_page = 1'b0;
        // slice 7 lands 8 cycles after the strobe
        repeat (8) @(negedge clk);
    endtask

    // first failed assertion ends the run
    always @(posedge clk) begin
        if (UUT.u_chk.err_count != 0) begin
            $display("STATUS: FAIL");
            $fatal(1, "bound checker reported a failed assertion");
        end
    end

    initial begin
        seed             = 32'h2829_2d1c;
        alloc_next       = '0;
        bank_idx         = 5'd9;
        wr_data_vld      = 1'b0;
        wr_data          = '0;
        wr_end_of_packet = 1'b0;
        concat_en        = 1'b0;
        concat_head      = '0;
        concat_tail      = '0;
        rd_another_page  = 1'b0;
        rd_page          = '0;

        wait_for_init();

        // three pages with a short last one
        send_packet(4'd3, 3'd5, 20, first_a);
        // exactly one full page
        send_packet(4'd12, 3'd1, 8, first_b);
        len_c = 9 + ($random(seed) & 15);
        send_packet(port_t'($random(seed)), prio_t'($random(seed)), len_c, first_c);
        // header only
        send_packet(4'd7, 3'd7, 1, first_d);

        // chain packet b onto packet d, away from its normal successor
        splice_packets({bank_idx, first_b}, {bank_idx, first_d});

        for (page_t p = first_a; p != alloc_next; p++) begin
            read_page(p);
        end

        repeat (2) @(negedge clk);
        if (UUT.u_chk.err_count == 0) begin
            $display("STATUS: PASS");
            $finish;
        end else begin
            $display("STATUS: FAIL");
            $fatal(1, "bound checker reported %0d failures", UUT.u_chk.err_count);
        end
    end

endmodule

// File: verif/pbuf_chk.sv
`include "pbuf_defines.svh"

module pbuf_chk import pbuf_pkg::*; (
    input logic                     clk,
    input logic                     rst_n,
    input logic [`PBUF_BANK_AW-1:0] bank_idx,
    input logic                     wr_data_vld,
    input half_t                    wr_data,
    input logic                     wr_end_of_packet,
    input logic                     wr_join_request,
    input port_t                    wr_dest_port,
    input prio_t                    wr_prior,
    input gaddr_t                   wr_head_addr,
    input gaddr_t                   wr_tail_addr,
    input logic                     concat_en,
    input gaddr_t                   concat_head,
    input gaddr_t                   concat_tail,
    input logic                     rd_another_page,
    input page_t                    rd_page,
    input half_t                    rd_data,
    input gaddr_t                   rd_next_page,
    input ecc_t                     rd_ecc_code,
    input logic                     init_done,
    input logic [`PBUF_CNT_W-1:0]   free_count
);

    // failed checks so far, watched by the testbench
    int err_count = 0;

    // reference image of the bank
    half_t      ref_data     [`PBUF_PAGES*`PBUF_SLICES];
    ecc_t       ref_ecc      [`PBUF_PAGES];
    gaddr_t     ref_link     [`PBUF_PAGES];
    logic       ref_link_vld [`PBUF_PAGES];
    // halfwords written into each page
    logic [3:0] ref_len      [`PBUF_PAGES];

    // write side tracking
    logic   in_pkt;
    page_t  alloc_ptr;
    page_t  wr_page;
    slice_t wr_slice;
    logic   hdr_d;
    half_t  hdr_q;
    page_t  head_q;

    // read side tracking
    logic       rd_active;
    slice_t     rd_cnt;
    page_t      rd_exp_page;
    logic [3:0] exp_len;
    gaddr_t     exp_link;
    logic       exp_link_vld;
    ecc_t       exp_ecc;
    half_t      exp_data;

    // splice target split into bank and page
    logic [`PBUF_BANK_AW-1:0] cat_bank;
    page_t                    cat_page;

    assign exp_data = ref_data[{rd_exp_page, rd_cnt}];
    assign cat_bank = concat_head[`PBUF_BANK_AW+`PBUF_PAGE_AW-1:`PBUF_PAGE_AW];
    assign cat_page = concat_head[`PBUF_PAGE_AW-1:0];

    always @(posedge clk) begin : model_upd
        page_t pg;
        if (!rst_n) begin
            in_pkt    <= 1'b0;
            alloc_ptr <= '0;
            wr_page   <= '0;
            wr_slice  <= '0;
            hdr_d     <= 1'b0;
            rd_active <= 1'b0;
            for (int i = 0; i < `PBUF_PAGES; i++) begin
                ref_link_vld[i] <= 1'b0;
            end
        end else begin
            // slot 0 opens a fresh page, pages leave in fill order
            pg = (wr_slice == '0) ? alloc_ptr : wr_page;
            hdr_d <= wr_data_vld && !in_pkt;
            if (wr_data_vld) begin
                ref_data[{pg, wr_slice}] <= wr_data;
                ref_len[pg] <= 4'(wr_slice) + 4'd1;
                wr_slice    <= wr_end_of_packet ? slice_t'(0) : wr_slice + 1'b1;
                in_pkt      <= !wr_end_of_packet;
                if (wr_slice == '0) begin
                    alloc_ptr   <= alloc_ptr + 1'b1;
                    wr_page     <= pg;
                    ref_ecc[pg] <= wr_data[15:8] ^ wr_data[7:0];
                    // previous page of the same packet points here
                    if (in_pkt) begin
                        ref_link[wr_page]     <= {bank_idx, pg};
                        ref_link_vld[wr_page] <= 1'b1;
                    end
                end else begin
                    ref_ecc[pg] <= ref_ecc[pg] ^ wr_data[15:8] ^ wr_data[7:0];
                end
                if (!in_pkt) begin
                    hdr_q  <= wr_data;
                    head_q <= pg;
                end
            end
            // splice, last so it wins over a normal link
            if (concat_en && cat_bank == bank_idx) begin
                ref_link[cat_page]     <= concat_tail;
                ref_link_vld[cat_page] <= 1'b1;
            end
            if (rd_another_page) begin
                rd_active    <= 1'b1;
                rd_cnt       <= '0;
                rd_exp_page  <= rd_page;
                exp_len      <= ref_len[rd_page];
                exp_link     <= ref_link[rd_page];
                exp_link_vld <= ref_link_vld[rd_page];
                exp_ecc      <= ref_ecc[rd_page];
            end else if (rd_active) begin
                rd_cnt    <= rd_cnt + 1'b1;
                rd_active <= (rd_cnt != 3'd7);
            end
        end
    end

    a_rst_quiet: assert property (@(posedge clk)
        $rose(rst_n) |-> !init_done && !wr_join_request)
        else begin
            err_count++;
            $error("[ERROR] %0t init_done or join request high right after reset", $time);
        end

    // full ring once the fill is over
    a_init_count: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(init_done) |-> free_count == 7'd64)
        else begin
            err_count++;
            $error("[ERROR] %0t free_count not 64 when init_done rose", $time);
        end

    // one pulse per header, nothing else
    a_join_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        wr_join_request == hdr_d)
        else begin
            err_count++;
            $error("[ERROR] %0t join request does not follow the header", $time);
        end

    a_join_fields: assert property (@(posedge clk) disable iff (!rst_n)
        hdr_d |-> wr_dest_port == hdr_q[3:0] && wr_prior == hdr_q[6:4])
        else begin
            err_count++;
            $error("[ERROR] %0t join port or priority differs from header", $time);
        end

    a_join_head: assert property (@(posedge clk) disable iff (!rst_n)
        hdr_d |-> wr_head_addr == {bank_idx, head_q})
        else begin
            err_count++;
            $error("[ERROR] %0t join head address wrong", $time);
        end

    // tail is the model's head page plus the length field
    a_join_tail: assert property (@(posedge clk) disable iff (!rst_n)
        hdr_d |-> wr_tail_addr == {bank_idx, page_t'(head_q + page_t'(hdr_q[9:7]))})
        else begin
            err_count++;
            $error("[ERROR] %0t join tail address wrong", $time);
        end

    // only slots that were written
    a_rd_data: assert property (@(posedge clk) disable iff (!rst_n)
        rd_active && (4'(rd_cnt) < exp_len) |-> rd_data == exp_data)
        else begin
            err_count++;
            $error("[ERROR] %0t read data wrong on slice %0d", $time, rd_cnt);
        end

    a_rd_link: assert property (@(posedge clk) disable iff (!rst_n)
        rd_active && exp_link_vld |-> rd_next_page == exp_link)
        else begin
            err_count++;
            $error("[ERROR] %0t read next page link wrong", $time);
        end

    a_rd_ecc: assert property (@(posedge clk) disable iff (!rst_n)
        rd_active |-> rd_ecc_code == exp_ecc)
        else begin
            err_count++;
            $error("[ERROR] %0t read check code wrong", $time);
        end

    // read page goes back to the queue
    a_free_back: assert property (@(posedge clk) disable iff (!rst_n)
        rd_another_page && !wr_data_vld
        |=> free_count == $past(free_count) + 7'd1)
        else begin
            err_count++;
            $error("[ERROR] %0t free_count did not grow after a page read", $time);
        end

endmodule

// File: verif/tb_clock_gen.sv
module tb_clock_gen (
    output logic clk,
    output logic rst_n
);

    // free running clock, period 100
    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // reset low over two rising edges, released on a falling edge
    initial begin
        rst_n = 1'b0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
    end

endmodule

// File: hw/pbuf_bank_top.sv
`include "pbuf_defines.svh"

module pbuf_bank_top import pbuf_pkg::*; (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic [`PBUF_BANK_AW-1:0] bank_idx,

    // packet write
    input  logic                     wr_data_vld,
    input  half_t                    wr_data,
    input  logic                     wr_end_of_packet,

    // enqueue request
    output logic                     wr_join_request,
    output port_t                    wr_dest_port,
    output prio_t                    wr_prior,
    output gaddr_t                   wr_head_addr,
    output gaddr_t                   wr_tail_addr,

    // splice of two packets
    input  logic                     concat_en,
    input  gaddr_t                   concat_head,
    input  gaddr_t                   concat_tail,

    // page read, the page also goes back to the free queue
    input  logic                     rd_another_page,
    input  page_t                    rd_page,
    output half_t                    rd_data,
    output gaddr_t                   rd_next_page,
    output ecc_t                     rd_ecc_code,

    output logic                     init_done,
    output logic [`PBUF_CNT_W-1:0]   free_count
);

    page_wr_if u_wr_if ();

    page_t                  head_page;
    page_t                  look_page;
    logic                   pop;
    logic [`PBUF_LEN_W-1:0] look_len;

    pkt_write_fsm u_write (
        .clk           (clk),
        .rst_n         (rst_n),
        .bank_idx      (bank_idx),
        .data_vld      (wr_data_vld),
        .data          (wr_data),
        .end_of_packet (wr_end_of_packet),
        .head_page     (head_page),
        .look_page     (look_page),
        .pop           (pop),
        .look_len      (look_len),
        .join_request  (wr_join_request),
        .dest_port     (wr_dest_port),
        .prior         (wr_prior),
        .head_addr     (wr_head_addr),
        .tail_addr     (wr_tail_addr),
        .wr            (u_wr_if)
    );

    // every page read is freed
    free_page_queue u_free_q (
        .clk        (clk),
        .rst_n      (rst_n),
        .pop        (pop),
        .push       (rd_another_page),
        .push_page  (rd_page),
        .look_len   (look_len),
        .head_page  (head_page),
        .look_page  (look_page),
        .init_done  (init_done),
        .free_count (free_count)
    );

    page_store u_store (
        .clk             (clk),
        .bank_idx        (bank_idx),
        .wr              (u_wr_if),
        .next_page       (head_page),
        .concat_en       (concat_en),
        .concat_head     (concat_head),
        .concat_tail     (concat_tail),
        .rd_another_page (rd_another_page),
        .rd_page         (rd_page),
        .rd_data         (rd_data),
        .rd_next_page    (rd_next_page),
        .rd_ecc_code     (rd_ecc_code)
    );

endmodule

// File: page_store/page_store.sv
`include "pbuf_defines.svh"

module page_store import pbuf_pkg::*; (
    input  logic                     clk,
    input  logic [`PBUF_BANK_AW-1:0] bank_idx,
    page_wr_if.store                 wr,
    input  page_t                    next_page,
    input  logic                     concat_en,
    input  gaddr_t                   concat_head,
    input  gaddr_t                   concat_tail,
    input  logic                     rd_another_page,
    input  page_t                    rd_page,
    output half_t                    rd_data,
    output gaddr_t                   rd_next_page,
    output ecc_t                     rd_ecc_code
);

    half_t  data_ram [`PBUF_PAGES*`PBUF_SLICES];
    gaddr_t jump_tab [`PBUF_PAGES];
    ecc_t   ecc_ram  [`PBUF_PAGES];

    // copy of the open page for the check code
    half_t  slice_buf     [`PBUF_SLICES];
    half_t  slice_buf_nxt [`PBUF_SLICES];
    ecc_t   page_code;
    logic   concat_hit;

    page_t  rd_page_q;
    page_t  rd_page_sel;
    slice_t rd_slice;
    slice_t rd_slice_sel;

    always_ff @(posedge clk) begin
        if (wr.slice_vld) begin
            data_ram[{wr.cur_page, wr.slice_idx}] <= wr.slice_data;
        end
    end

    // buffer as it stands after this edge
    // slot 0 wipes stale slots so a short page codes them as zero
    always_comb begin
        slice_buf_nxt = slice_buf;
        if (wr.slice_vld) begin
            if (wr.slice_idx == '0) begin
                for (int i = 1; i < `PBUF_SLICES; i++) begin
                    slice_buf_nxt[i] = '0;
                end
            end
            slice_buf_nxt[wr.slice_idx] = wr.slice_data;
        end
    end

    always_ff @(posedge clk) begin
        slice_buf <= slice_buf_nxt;
    end

    page_ecc_encoder u_ecc_enc (
        .slices (slice_buf_nxt),
        .code   (page_code)
    );

    // code lands together with the page's last halfword
    always_ff @(posedge clk) begin
        if (wr.page_end) begin
            ecc_ram[wr.cur_page] <= page_code;
        end
    end

    // only heads that live in this bank
    assign concat_hit = concat_en
        && (concat_head[`PBUF_BANK_AW+`PBUF_PAGE_AW-1:`PBUF_PAGE_AW] == bank_idx);

    // packet splice first, otherwise link current page to the queue head
    always_ff @(posedge clk) begin
        if (concat_hit) begin
            jump_tab[concat_head[`PBUF_PAGE_AW-1:0]] <= concat_tail;
        end else if (wr.slice_vld) begin
            jump_tab[wr.cur_page] <= {bank_idx, next_page};
        end
    end

    // new page starts at slot 0, held page runs on its own counter
    assign rd_page_sel  = rd_another_page ? rd_page : rd_page_q;
    assign rd_slice_sel = rd_another_page ? slice_t'(0) : rd_slice;

    always_ff @(posedge clk) begin
        if (rd_another_page) begin
            rd_slice <= slice_t'(1);
        end else begin
            rd_slice <= rd_slice + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        rd_data <= data_ram[{rd_page_sel, rd_slice_sel}];
    end

    // link and code stay put for the whole page
    always_ff @(posedge clk) begin
        if (rd_another_page) begin
            rd_page_q    <= rd_page;
            rd_next_page <= jump_tab[rd_page];
            rd_ecc_code  <= ecc_ram[rd_page];
        end
    end

endmodule

// File: page_store/page_ecc_encoder.sv
`include "pbuf_defines.svh"

module page_ecc_encoder import pbuf_pkg::*; (
    input  half_t slices [`PBUF_SLICES],
    output ecc_t  code
);

    // xor of all sixteen bytes
    // zeroed slots drop out on their own
    always_comb begin
        code = '0;
        for (int i = 0; i < `PBUF_SLICES; i++) begin
            // high byte, then low byte
            code = code ^ slices[i][15:8];
            code = code ^ slices[i][7:0];
        end
    end

endmodule

// File: free_list/free_page_queue.sv
`include "pbuf_defines.svh"

module free_page_queue import pbuf_pkg::*; (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   pop,
    input  logic                   push,
    input  page_t                  push_page,
    input  logic [`PBUF_LEN_W-1:0] look_len,
    output page_t                  head_page,
    output page_t                  look_page,
    output logic                   init_done,
    output logic [`PBUF_CNT_W-1:0] free_count
);

    // ring of free page numbers
    page_t ring [`PBUF_PAGES];

    logic [`PBUF_PAGE_AW-1:0] pop_ptr;
    logic [`PBUF_PAGE_AW-1:0] push_ptr;
    logic [`PBUF_PAGE_AW-1:0] look_ptr;
    // fill progress after reset, doubles as the page written
    logic [`PBUF_CNT_W-1:0]   fill_cnt;
    logic                     filling;
    logic                     wr_en;

    assign filling   = (fill_cnt != `PBUF_CNT_W'(`PBUF_PAGES));
    assign init_done = !filling;
    // returned pages win over the fill, the fill just waits
    assign wr_en     = push || filling;

    always_ff @(posedge clk) begin
        if (push) begin
            ring[push_ptr] <= push_page;
        end else if (filling) begin
            ring[push_ptr] <= fill_cnt[`PBUF_PAGE_AW-1:0];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pop_ptr    <= '0;
            push_ptr   <= '0;
            fill_cnt   <= '0;
            free_count <= '0;
        end else begin
            if (pop) begin
                pop_ptr <= pop_ptr + 1'b1;
            end
            if (wr_en) begin
                push_ptr <= push_ptr + 1'b1;
            end
            if (!push && filling) begin
                fill_cnt <= fill_cnt + 1'b1;
            end
            // simultaneous entry and pop leave the count alone
            if (wr_en && !pop) begin
                free_count <= free_count + 1'b1;
            end else if (!wr_en && pop) begin
                free_count <= free_count - 1'b1;
            end
        end
    end

    // registered head, one cycle behind pop_ptr
    always_ff @(posedge clk) begin
        head_page <= ring[pop_ptr];
    end

    // predicted tail, needed in the header cycle itself
    assign look_ptr  = pop_ptr + `PBUF_PAGE_AW'(look_len);
    assign look_page = ring[look_ptr];

endmodule

// File: hw/pkt_write_fsm.sv
`include "pbuf_defines.svh"

module pkt_write_fsm import pbuf_pkg::*; (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic [`PBUF_BANK_AW-1:0] bank_idx,
    input  logic                     data_vld,
    input  half_t                    data,
    input  logic                     end_of_packet,
    input  page_t                    head_page,
    input  page_t                    look_page,
    output logic                     pop,
    output logic [`PBUF_LEN_W-1:0]   look_len,
    output logic                     join_request,
    output port_t                    dest_port,
    output prio_t                    prior,
    output gaddr_t                   head_addr,
    output gaddr_t                   tail_addr,
    page_wr_if.ctrl                  wr
);

    wr_state_t state;
    page_t     cur_page;
    logic      page_end;
    logic      refetch;
    logic      hdr;

    slice_counter u_slice_cnt (
        .clk           (clk),
        .rst_n         (rst_n),
        .slice_vld     (data_vld),
        .end_of_packet (end_of_packet),
        .slice_idx     (wr.slice_idx),
        .page_end      (page_end),
        .refetch       (refetch)
    );

    // first halfword of a packet carries the header
    assign hdr = (state == WR_IDLE) && data_vld;

    // current page leaves the free queue with its first slot
    assign pop = data_vld && (wr.slice_idx == '0);

    // header bits 9:7, tail sits that many entries past the queue head
    assign look_len = data[9:7];

    assign wr.slice_vld  = data_vld;
    assign wr.slice_data = data;
    assign wr.cur_page   = cur_page;
    assign wr.page_end   = page_end;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= WR_IDLE;
        end else begin
            case (state)
                WR_IDLE: begin
                    if (hdr && !end_of_packet) begin
                        state <= WR_FIRST;
                    end
                end
                WR_FIRST: begin
                    if (end_of_packet) begin
                        state <= WR_IDLE;
                    end else if (page_end) begin
                        state <= WR_NEXT;
                    end
                end
                WR_NEXT: begin
                    if (end_of_packet) begin
                        state <= WR_IDLE;
                    end
                end
                default: state <= WR_IDLE;
            endcase
        end
    end

    // queue head is the page after the one being filled
    // refetch picks it up again once a late pop has settled
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cur_page <= '0;
        end else if (page_end || refetch) begin
            cur_page <= head_page;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            join_request <= 1'b0;
        end else begin
            join_request <= hdr;
        end
    end

    // enqueue fields, valid with join_request
    always_ff @(posedge clk) begin
        if (hdr) begin
            dest_port <= data[3:0];
            prior     <= data[6:4];
            head_addr <= {bank_idx, cur_page};
            tail_addr <= {bank_idx, look_page};
        end
    end

endmodule

// File: hw/slice_counter.sv
`include "pbuf_defines.svh"

module slice_counter import pbuf_pkg::*; (
    input  logic   clk,
    input  logic   rst_n,
    input  logic   slice_vld,
    input  logic   end_of_packet,
    output slice_t slice_idx,
    output logic   page_end,
    output logic   refetch
);

    logic eop_d;

    // page closes on its last slot
    // or when a packet stops inside an open page
    assign page_end = (slice_vld && slice_idx == slice_t'(`PBUF_SLICES - 1))
                    || (end_of_packet && (slice_vld || slice_idx != '0));

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            slice_idx <= '0;
            eop_d     <= 1'b0;
            refetch   <= 1'b0;
        end else begin
            // next packet always starts at slot 0
            if (end_of_packet) begin
                slice_idx <= '0;
            end else if (slice_vld) begin
                slice_idx <= slice_idx + 1'b1;
            end
            // two stage delay, free queue head needs a cycle after a late pop
            eop_d   <= end_of_packet;
            refetch <= eop_d;
        end
    end

endmodule

// File: common/page_wr_if.sv
interface page_wr_if import pbuf_pkg::*; ();

    // halfword strobe, one per cycle at most
    logic   slice_vld;
    // slot of the halfword in the current page
    slice_t slice_idx;
    half_t  slice_data;
    // page being filled
    page_t  cur_page;
    // last slot of a page, or end of a short page
    logic   page_end;

    // write control side
    modport ctrl (
        output slice_vld, slice_idx, slice_data, cur_page, page_end
    );

    // storage side
    modport store (
        input slice_vld, slice_idx, slice_data, cur_page, page_end
    );

endinterface

// File: common/pbuf_pkg.sv
`include "pbuf_defines.svh"

package pbuf_pkg;

    // one halfword of packet data
    typedef logic [`PBUF_HALF_W-1:0] half_t;

    // page number inside the bank
    typedef logic [`PBUF_PAGE_AW-1:0] page_t;

    // halfword slot inside a page
    typedef logic [`PBUF_SLICE_AW-1:0] slice_t;

    // bank index on top, page number below
    typedef logic [`PBUF_BANK_AW+`PBUF_PAGE_AW-1:0] gaddr_t;

    typedef logic [`PBUF_ECC_W-1:0] ecc_t;
    typedef logic [`PBUF_PORT_W-1:0] port_t;
    typedef logic [`PBUF_PRIO_W-1:0] prio_t;

    // packet write progress
    typedef enum logic [1:0] {
        WR_IDLE,
        WR_FIRST,
        WR_NEXT
    } wr_state_t;

endpackage

// File: common/pbuf_defines.svh
`ifndef PBUF_DEFINES_SVH
`define PBUF_DEFINES_SVH

// bank geometry
`define PBUF_PAGES     64
`define PBUF_PAGE_AW   6
`define PBUF_SLICES    8
`define PBUF_SLICE_AW  3
`define PBUF_BANK_AW   5

// field widths
`define PBUF_HALF_W    16
`define PBUF_ECC_W     8
`define PBUF_PORT_W    4
`define PBUF_PRIO_W    3
// length field of the header, pages minus one
`define PBUF_LEN_W     3
// free page count, 0 to PBUF_PAGES
`define PBUF_CNT_W     7

`endif
